// ==== sources.f ====
+incdir+bench
common/bouncy_pkg.sv
common/motion_if.sv
logic/frame_sequencer.sv
logic/pixel_plotter.sv
logic/object_motion.sv
logic/bouncy_ball_top.sv
bench/tb_bouncy_ball.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bouncy ball testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_bouncy_ball
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_bouncy_ball \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== bench/tb_game_model.svh ====
`ifndef TB_GAME_MODEL_SVH
`define TB_GAME_MODEL_SVH

// Game state that the next frame is expected to show
int model_ball_x;
int model_ball_y;
int model_paddle_x;
bit model_right;
bit model_down;

// Start positions after reset or go
task automatic model_restart();
    model_ball_x   = 0;
    model_ball_y   = 0;
    model_right    = 1'b1;
    model_down     = 1'b0;
    model_paddle_x = 0;
endtask

// Offset of the n-th ball pixel, 4x4 box scanned row by row without corners
task automatic ball_pixel(input int index, output int dx, output int dy);
    int n;
    int r;
    int c;
    n  = 0;
    dx = 0;
    dy = 0;
    for (r = 0; r < BALL_SIZE; r++) begin
        for (c = 0; c < BALL_SIZE; c++) begin
            if (!((r == 0 || r == BALL_SIZE - 1) && (c == 0 || c == BALL_SIZE - 1))) begin
                if (n == index) begin
                    dx = c;
                    dy = r;
                end
                n++;
            end
        end
    end
endtask

// Contact, bounce and move for one frame with the keys held in it
task automatic model_step(input bit left_in, input bit right_in);
    bit at_left;
    bit at_right;
    bit at_top;
    bit at_bottom;
    bit overlap;
    bit touching;
    at_left   = (model_ball_x == 0);
    at_right  = (model_ball_x >= SCREEN_W - 4);
    at_top    = (model_ball_y == 0);
    at_bottom = (model_ball_y == SCREEN_H - 6);
    overlap   = (model_ball_x + 3 >= model_paddle_x) &&
                (model_ball_x <= model_paddle_x + PADDLE_W - 1);
    touching  = at_left || at_top || at_right || (at_bottom && overlap);
    if (touching) begin
        if (at_left)
            model_right = 1'b1;
        else if (at_right)
            model_right = 1'b0;
        if (at_top)
            model_down = 1'b1;
        else if (at_bottom)
            model_down = 1'b0;
    end
    if (at_bottom && model_down && !touching) begin
        // Missed paddle, ball starts over
        model_ball_x = 0;
        model_ball_y = 0;
        model_right  = 1'b1;
        model_down   = 1'b0;
    end else begin
        model_ball_x = model_right ? model_ball_x + 1 : model_ball_x - 1;
        model_ball_y = model_down ? model_ball_y + 1 : model_ball_y - 1;
    end
    if (left_in && model_paddle_x != 0)
        model_paddle_x = model_paddle_x - 1;
    else if (right_in && model_paddle_x < SCREEN_W - PADDLE_W)
        model_paddle_x = model_paddle_x + 1;
endtask

`endif

// ==== bench/tb_bouncy_ball.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bouncy_ball import bouncy_pkg::*; ();

    localparam int SCREEN_W    = 24;
    localparam int SCREEN_H    = 16;
    localparam int PADDLE_W    = 6;
    localparam int WAIT_CYCLES = 3;
    localparam int CLK_PERIOD  = 10;
    localparam int NUM_ROWS    = 57;

    // One full frame from start state through move
    localparam int FRAME_CYCLES = 1 + SCREEN_H * (SCREEN_W + 1) + 1 + BALL_PIXELS + 1
                                  + PADDLE_ROWS * (PADDLE_W + 1) + 1 + WAIT_CYCLES + 3;
    localparam int TIMEOUT_CYCLES = 20 + (NUM_ROWS + 2) * FRAME_CYCLES + 500;

    // Row bits are {go, left_key, right_key}
    localparam logic [2:0] KEYS_NONE = 3'b000;
    localparam logic [2:0] KEY_RIGHT = 3'b001;
    localparam logic [2:0] KEY_LEFT  = 3'b010;
    localparam logic [2:0] KEY_BOTH  = 3'b011;
    localparam logic [2:0] GO        = 3'b100;

    localparam logic [2:0] STIM [NUM_ROWS] = '{
        // Paddle runs right into its stop at 18
        KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT,
        KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT,
        KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT,
        KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT,
        // Paddle parked far right while the ball comes down
        KEYS_NONE, KEYS_NONE, KEYS_NONE, KEYS_NONE, KEYS_NONE, KEYS_NONE,
        KEYS_NONE, KEYS_NONE,
        // Back left to the stop at 0
        KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT,
        KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT,
        KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT, KEY_LEFT,
        KEY_BOTH,
        GO,
        KEYS_NONE, KEYS_NONE, KEYS_NONE, KEYS_NONE
    };

    logic    clk;
    logic    resetn;
    logic    left_key;
    logic    right_key;
    logic    go;
    logic    plot;
    pos_x_t  x;
    pos_y_t  y;
    colour_t colour;
    bit      after_go;
    int      row_idx;

    `include "tb_game_model.svh"

    bouncy_ball_top #(
        .SCREEN_WIDTH  (SCREEN_W),
        .SCREEN_HEIGHT (SCREEN_H),
        .PADDLE_WIDTH  (PADDLE_W),
        .WAIT_CYCLES   (WAIT_CYCLES)
    ) dut0 (
        .clk       (clk),
        .resetn    (resetn),
        .left_key  (left_key),
        .right_key (right_key),
        .go        (go),
        .plot      (plot),
        .x         (x),
        .y         (y),
        .colour    (colour)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run stopped without finishing after %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // Next plotted pixel, looked at on a falling edge
    task automatic wait_pixel();
        do
            @(negedge clk);
        while (plot !== 1'b1);
    endtask

    // Strict mode allows no stray pixel before black (0,0)
    task automatic wait_frame_start(input bit strict);
        bit found;
        found = 1'b0;
        while (!found) begin
            wait_pixel();
            found = (x == '0) && (y == '0) && (colour == COLOUR_BACKGROUND);
            if (strict) begin
                check_value("x", 32'(x), 32'd0);
                check_value("y", 32'(y), 32'd0);
                check_value("colour", 32'(colour), 32'(COLOUR_BACKGROUND));
            end
        end
    endtask

    // Rest of the frame after its first background pixel
    task automatic check_frame();
        int k;
        int dx;
        int dy;
        for (k = 1; k < SCREEN_W * SCREEN_H; k++) begin
            wait_pixel();
            check_value("colour", 32'(colour), 32'(COLOUR_BACKGROUND));
            check_value("x", 32'(x), 32'(k % SCREEN_W));
            check_value("y", 32'(y), 32'(k / SCREEN_W));
        end
        for (k = 0; k < BALL_PIXELS; k++) begin
            wait_pixel();
            ball_pixel(k, dx, dy);
            check_value("colour", 32'(colour), 32'(COLOUR_BALL));
            check_value("x", 32'(x), 32'(model_ball_x + dx));
            check_value("y", 32'(y), 32'(model_ball_y + dy));
        end
        // Bottom row first and the row above next
        for (k = 0; k < PADDLE_ROWS * PADDLE_W; k++) begin
            wait_pixel();
            check_value("colour", 32'(colour), 32'(COLOUR_PADDLE));
            check_value("x", 32'(x), 32'(model_paddle_x + k % PADDLE_W));
            check_value("y", 32'(y), 32'(SCREEN_H - 1 - k / PADDLE_W));
        end
    endtask

    initial begin
        resetn      = 1'b0;
        left_key    = 1'b0;
        right_key   = 1'b0;
        go          = 1'b0;
        after_go    = 1'b0;
        model_restart();
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
            wait_frame_start(!after_go);
            @(posedge clk);
            go        <= STIM[row_idx][2];
            left_key  <= STIM[row_idx][1];
            right_key <= STIM[row_idx][0];
            if (STIM[row_idx][2]) begin
                // One-cycle pulse aborts this frame
                @(posedge clk);
                go <= 1'b0;
                model_restart();
                after_go = 1'b1;
            end else begin
                after_go = 1'b0;
                check_frame();
                model_step(STIM[row_idx][1], STIM[row_idx][0]);
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/bouncy_ball_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bouncy_ball_top import bouncy_pkg::*; #(
    parameter int SCREEN_WIDTH  = 160,
    parameter int SCREEN_HEIGHT = 120,
    parameter int PADDLE_WIDTH  = 18,
    parameter int WAIT_CYCLES   = 12500000
) (
    input  logic    clk,
    input  logic    resetn,
    input  logic    left_key,
    input  logic    right_key,
    input  logic    go,
    output logic    plot,
    output pos_x_t  x,
    output pos_y_t  y,
    output colour_t colour
);

    motion_if motion ();

    draw_phase_t               phase;
    logic [$bits(pos_x_t)-1:0] col;
    logic [$bits(pos_y_t)-1:0] row;
    playfield_t                playfield;

    frame_sequencer #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT),
        .PADDLE_WIDTH  (PADDLE_WIDTH),
        .WAIT_CYCLES   (WAIT_CYCLES)
    ) u_sequencer (
        .clk    (clk),
        .resetn (resetn),
        .go     (go),
        .phase  (phase),
        .col    (col),
        .row    (row),
        .motion (motion.sequencer)
    );

    pixel_plotter #(
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) u_plotter (
        .clk       (clk),
        .resetn    (resetn),
        .phase     (phase),
        .col       (col),
        .row       (row),
        .playfield (playfield),
        .plot      (plot),
        .x         (x),
        .y         (y),
        .colour    (colour)
    );

    object_motion #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT),
        .PADDLE_WIDTH  (PADDLE_WIDTH)
    ) u_motion (
        .clk       (clk),
        .resetn    (resetn),
        .left_key  (left_key),
        .right_key (right_key),
        .motion    (motion.mover),
        .playfield (playfield)
    );

endmodule

`default_nettype wire

// ==== logic/object_motion.sv ====
`timescale 1ns/1ps
`default_nettype none

module object_motion import bouncy_pkg::*; #(
    parameter int SCREEN_WIDTH  = 160,
    parameter int SCREEN_HEIGHT = 120,
    parameter int PADDLE_WIDTH  = 18
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       left_key,
    input  logic       right_key,
    motion_if.mover    motion,
    output playfield_t playfield
);

    // Ball box touches the right wall here
    localparam pos_x_t RIGHT_X    = pos_x_t'(SCREEN_WIDTH - BALL_SIZE);
    // Bottom line sits just above the paddle rows
    localparam pos_y_t BOTTOM_Y   = pos_y_t'(SCREEN_HEIGHT - BALL_SIZE - PADDLE_ROWS);
    localparam pos_x_t PADDLE_MAX = pos_x_t'(SCREEN_WIDTH - PADDLE_WIDTH);

    pos_x_t    ball_x;
    pos_y_t    ball_y;
    pos_x_t    paddle_x;
    ball_dir_t dir;

    logic       at_left;
    logic       at_right;
    logic       at_top;
    logic       at_bottom;
    logic       overlap;
    logic       heading_right;
    logic       heading_down;
    logic [8:0] ball_right_edge;
    logic [8:0] paddle_right_edge;

    function automatic ball_dir_t make_dir(input logic right, input logic down);
        case ({right, down})
            2'b10:   return dir_up_right;
            2'b11:   return dir_down_right;
            2'b01:   return dir_down_left;
            default: return dir_up_left;
        endcase
    endfunction

    assign at_left   = (ball_x == '0);
    assign at_right  = (ball_x >= RIGHT_X);
    assign at_top    = (ball_y == '0);
    assign at_bottom = (ball_y == BOTTOM_Y);

    // 9-bit edges so the sums cannot wrap
    assign ball_right_edge   = {1'b0, ball_x} + 9'(BALL_SIZE - 1);
    assign paddle_right_edge = {1'b0, paddle_x} + 9'(PADDLE_WIDTH - 1);
    assign overlap = (ball_right_edge >= {1'b0, paddle_x}) &&
                     ({1'b0, ball_x} <= paddle_right_edge);

    assign heading_right = (dir == dir_up_right) || (dir == dir_down_right);
    assign heading_down  = (dir == dir_down_right) || (dir == dir_down_left);

    always_ff @(posedge clk) begin
        if (!resetn || motion.reset_objects)
            motion.touching <= 1'b0;
        else if (motion.check_contact)
            motion.touching <= at_left || at_top || at_right || (at_bottom && overlap);
    end

    always_ff @(posedge clk) begin
        if (!resetn || motion.reset_objects) begin
            ball_x <= '0;
            ball_y <= '0;
            dir    <= dir_up_right;
        end else if (motion.bounce) begin
            // Each component points away from any wall it touches
            dir <= make_dir(at_left ? 1'b1 : (at_right ? 1'b0 : heading_right),
                            at_top ? 1'b1 : (at_bottom ? 1'b0 : heading_down));
        end else if (motion.move) begin
            if (at_bottom && heading_down && !motion.touching) begin
                // Missed the paddle
                ball_x <= '0;
                ball_y <= '0;
                dir    <= dir_up_right;
            end else begin
                ball_x <= heading_right ? ball_x + 8'd1 : ball_x - 8'd1;
                ball_y <= heading_down ? ball_y + 7'd1 : ball_y - 7'd1;
            end
        end
    end

    // Left key wins when both are held
    always_ff @(posedge clk) begin
        if (!resetn || motion.reset_objects)
            paddle_x <= '0;
        else if (motion.move) begin
            if (left_key && paddle_x != '0)
                paddle_x <= paddle_x - 8'd1;
            else if (right_key && paddle_x < PADDLE_MAX)
                paddle_x <= paddle_x + 8'd1;
        end
    end

    assign playfield = '{ball_x: ball_x, ball_y: ball_y, paddle_x: paddle_x};

endmodule

`default_nettype wire

// ==== logic/pixel_plotter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_plotter import bouncy_pkg::*; #(
    parameter int SCREEN_HEIGHT = 120
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  draw_phase_t               phase,
    input  logic [$bits(pos_x_t)-1:0] col,
    input  logic [$bits(pos_y_t)-1:0] row,
    input  playfield_t                playfield,
    output logic                      plot,
    output pos_x_t                    x,
    output pos_y_t                    y,
    output colour_t                   colour
);

    logic [3:0] ball_idx;
    logic [1:0] ball_dx;
    logic [1:0] ball_dy;

    assign ball_idx = col[3:0];

    // Pixel index to offset in the rounded shape, row by row from the top
    always_comb begin
        if (ball_idx < 4'd2) begin
            ball_dy = 2'd0;
            ball_dx = 2'(ball_idx + 4'd1);
        end else if (ball_idx < 4'd6) begin
            ball_dy = 2'd1;
            ball_dx = 2'(ball_idx - 4'd2);
        end else if (ball_idx < 4'd10) begin
            ball_dy = 2'd2;
            ball_dx = 2'(ball_idx - 4'd6);
        end else begin
            ball_dy = 2'd3;
            ball_dx = 2'(ball_idx - 4'd9);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            plot <= 1'b0;
        else
            plot <= (phase != phase_none);
    end

    always_ff @(posedge clk) begin
        case (phase)
            phase_ball: begin
                x      <= playfield.ball_x + pos_x_t'(ball_dx);
                y      <= playfield.ball_y + pos_y_t'(ball_dy);
                colour <= COLOUR_BALL;
            end
            // Paddle rows count up from the bottom line of the screen
            phase_paddle: begin
                x      <= playfield.paddle_x + col;
                y      <= pos_y_t'(SCREEN_HEIGHT - 1) - row;
                colour <= COLOUR_PADDLE;
            end
            default: begin
                x      <= col;
                y      <= row;
                colour <= COLOUR_BACKGROUND;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import bouncy_pkg::*; #(
    parameter int SCREEN_WIDTH  = 160,
    parameter int SCREEN_HEIGHT = 120,
    parameter int PADDLE_WIDTH  = 18,
    parameter int WAIT_CYCLES   = 12500000
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      go,
    output draw_phase_t               phase,
    output logic [$bits(pos_x_t)-1:0] col,
    output logic [$bits(pos_y_t)-1:0] row,
    motion_if.sequencer               motion
);

    localparam int COL_W  = $bits(pos_x_t);
    localparam int ROW_W  = $bits(pos_y_t);
    localparam int WAIT_W = $clog2(WAIT_CYCLES + 1);
    // Column counter doubles as the wait counter
    localparam int CNT_W  = (WAIT_W > COL_W) ? WAIT_W : COL_W;

    typedef enum logic [3:0] {
        st_reset,
        st_init,
        st_start_background,
        st_background_row,
        st_background_next_row,
        st_start_ball,
        st_draw_ball,
        st_start_paddle,
        st_paddle_row,
        st_paddle_next_row,
        st_start_wait,
        st_wait,
        st_check,
        st_bounce,
        st_move
    } state_t;

    state_t            state;
    state_t            next_state;
    logic [CNT_W-1:0]  cnt;
    logic [ROW_W-1:0]  row_cnt;
    logic              cnt_clear;
    logic              cnt_inc;
    logic              row_clear;
    logic              row_inc;

    always_comb begin
        next_state = state;
        case (state)
            st_reset:               next_state = st_init;
            st_init:                next_state = st_start_background;
            st_start_background:    next_state = st_background_row;
            st_background_row:
                if (cnt == CNT_W'(SCREEN_WIDTH - 1))
                    next_state = st_background_next_row;
            st_background_next_row:
                next_state = (row_cnt == ROW_W'(SCREEN_HEIGHT - 1)) ?
                             st_start_ball : st_background_row;
            st_start_ball:          next_state = st_draw_ball;
            st_draw_ball:
                if (cnt == CNT_W'(BALL_PIXELS - 1))
                    next_state = st_start_paddle;
            st_start_paddle:        next_state = st_paddle_row;
            st_paddle_row:
                if (cnt == CNT_W'(PADDLE_WIDTH - 1))
                    next_state = st_paddle_next_row;
            st_paddle_next_row:
                next_state = (row_cnt == ROW_W'(PADDLE_ROWS - 1)) ?
                             st_start_wait : st_paddle_row;
            st_start_wait:          next_state = st_wait;
            st_wait:
                if (cnt == CNT_W'(WAIT_CYCLES - 1))
                    next_state = st_check;
            st_check:               next_state = st_bounce;
            // Touching is valid here, one cycle after the check strobe
            st_bounce:
                next_state = motion.touching ? st_move : st_start_background;
            st_move:                next_state = st_start_background;
            default:                next_state = st_reset;
        endcase
        if (go)
            next_state = st_init;
    end

    always_comb begin
        phase                = phase_none;
        cnt_clear            = 1'b0;
        cnt_inc              = 1'b0;
        row_clear            = 1'b0;
        row_inc              = 1'b0;
        motion.reset_objects = 1'b0;
        motion.check_contact = 1'b0;
        motion.bounce        = 1'b0;
        motion.move          = 1'b0;
        case (state)
            st_init: begin
                motion.reset_objects = 1'b1;
                cnt_clear            = 1'b1;
                row_clear            = 1'b1;
            end
            st_start_background, st_start_paddle: begin
                cnt_clear = 1'b1;
                row_clear = 1'b1;
            end
            st_background_row: begin
                phase   = phase_background;
                cnt_inc = 1'b1;
            end
            st_background_next_row, st_paddle_next_row: begin
                cnt_clear = 1'b1;
                row_inc   = 1'b1;
            end
            st_start_ball, st_start_wait:
                cnt_clear = 1'b1;
            st_draw_ball: begin
                phase   = phase_ball;
                cnt_inc = 1'b1;
            end
            st_paddle_row: begin
                phase   = phase_paddle;
                cnt_inc = 1'b1;
            end
            st_wait:
                cnt_inc = 1'b1;
            st_check:
                motion.check_contact = 1'b1;
            // No contact skips straight to the move step
            st_bounce: begin
                motion.bounce = motion.touching;
                motion.move   = !motion.touching;
            end
            st_move:
                motion.move = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= st_reset;
            cnt     <= '0;
            row_cnt <= '0;
        end else begin
            state <= next_state;
            if (cnt_clear)
                cnt <= '0;
            else if (cnt_inc)
                cnt <= cnt + 1'b1;
            if (row_clear)
                row_cnt <= '0;
            else if (row_inc)
                row_cnt <= row_cnt + 1'b1;
        end
    end

    assign col = cnt[COL_W-1:0];
    assign row = row_cnt;

endmodule

`default_nettype wire

// ==== common/motion_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Physics step strobes from the frame FSM, contact answer back
interface motion_if;
    logic reset_objects;
    logic check_contact;
    logic bounce;
    logic move;
    logic touching;

    modport sequencer (
        output reset_objects, check_contact, bounce, move,
        input  touching
    );

    modport mover (
        input  reset_objects, check_contact, bounce, move,
        output touching
    );
endinterface

`default_nettype wire

// ==== common/bouncy_pkg.sv ====
`default_nettype none

package bouncy_pkg;

    // Screen coordinates, sized for a 160x120 plotter
    typedef logic [7:0] pos_x_t;
    typedef logic [6:0] pos_y_t;

    // One bit each of red, green and blue
    typedef logic [2:0] colour_t;

    localparam colour_t COLOUR_BACKGROUND = 3'b000;
    localparam colour_t COLOUR_BALL       = 3'b111;
    localparam colour_t COLOUR_PADDLE     = 3'b011;

    // Ball is a 4x4 box with the corners knocked off
    localparam int BALL_SIZE   = 4;
    localparam int BALL_PIXELS = 12;

    localparam int PADDLE_ROWS = 2;

    // What the raster step in this cycle paints
    typedef enum logic [1:0] {
        phase_none,
        phase_background,
        phase_ball,
        phase_paddle
    } draw_phase_t;

    // Screen y grows downwards, so "up" decrements y
    typedef enum logic [1:0] {
        dir_up_right,
        dir_down_right,
        dir_down_left,
        dir_up_left
    } ball_dir_t;

    typedef struct packed {
        pos_x_t ball_x;
        pos_y_t ball_y;
        pos_x_t paddle_x;
    } playfield_t;

endpackage

`default_nettype wire
